/* rtl/fusion_pkg.sv */
// Sizes, fixed-point helpers, weight tables and payload types shared by the fusion RTL and testbench
package fusion_pkg;

    localparam int N_SENSORS = 3;
    localparam int N_WORDS   = 4;
    localparam int WORD_W    = 16;
    localparam int SCORE_W   = 32;
    localparam int FRAC_BITS = 8;   // Q8.8 scaling of V by the score
    localparam int HIST_LEN  = 3;   // Bad requests in a row before a persistent fault

    typedef logic signed [WORD_W-1:0] sample_t;
    typedef sample_t [N_WORDS-1:0] vec_t;

    typedef struct packed {
        logic [WORD_W-1:0] checksum;
        vec_t              data;
    } sensor_frame_t;

    typedef sensor_frame_t [N_SENSORS-1:0] frame_set_t;

    typedef struct packed {
        vec_t q;
        vec_t k;
        vec_t v;
    } qkv_t;

    typedef logic signed [SCORE_W-1:0] score_t;

    typedef struct packed {
        logic reserved;     // Always 0
        logic loss_err;
        logic range_err;
        logic checksum_err;
    } fault_code_t;

    typedef vec_t [N_SENSORS-1:0] fused_set_t;  // Sensor 0 in the low word group

    // Projection weights, indexed [output word][input word]
    localparam sample_t W_Q [N_WORDS][N_WORDS] = '{
        '{ 1,  0, -1,  2},
        '{ 0,  2,  1, -1},
        '{-1,  1,  0,  1},
        '{ 2, -1,  1,  0}
    };
    localparam sample_t W_K [N_WORDS][N_WORDS] = '{
        '{ 1,  1,  0, -1},
        '{-2,  0,  1,  1},
        '{ 0, -1,  2,  0},
        '{ 1,  0, -1,  3}
    };
    localparam sample_t W_V [N_WORDS][N_WORDS] = '{
        '{ 2,  0,  1,  0},
        '{ 0,  1, -1,  2},
        '{ 1, -2,  0,  1},
        '{-1,  0,  3,  1}
    };

    localparam longint WORD_MAX  = (longint'(1) << (WORD_W - 1)) - 1;
    localparam longint WORD_MIN  = -(longint'(1) << (WORD_W - 1));
    localparam longint SCORE_MAX = (longint'(1) << (SCORE_W - 1)) - 1;
    localparam longint SCORE_MIN = -(longint'(1) << (SCORE_W - 1));

    // Clamp a wide signed value into one data word
    function automatic sample_t sat_word(input logic signed [63:0] value);
        if (value > WORD_MAX)
            return sample_t'(WORD_MAX);
        if (value < WORD_MIN)
            return sample_t'(WORD_MIN);
        return sample_t'(value);
    endfunction

    function automatic score_t sat_score(input logic signed [63:0] value);
        if (value > SCORE_MAX)
            return score_t'(SCORE_MAX);
        if (value < SCORE_MIN)
            return score_t'(SCORE_MIN);
        return score_t'(value);
    endfunction

endpackage

/* rtl/sensor_conditioner.sv */
// Clamps every data word of one sensor frame into the clip window set by the top level
`timescale 1ns/1ps

module sensor_conditioner #(
    parameter int CLIP_MIN = -16384,
    parameter int CLIP_MAX = 16383
) (
    input  fusion_pkg::sensor_frame_t frame,
    output fusion_pkg::vec_t          conditioned
);

    // Checksum is consumed by the fault monitor only
    always_comb begin : clip_words
        fusion_pkg::sample_t word;
        for (int i = 0; i < fusion_pkg::N_WORDS; i++) begin
            word = $signed(frame.data[i]);
            if (word < CLIP_MIN) begin
                conditioned[i] = fusion_pkg::sample_t'(CLIP_MIN);
            end else if (word > CLIP_MAX) begin
                conditioned[i] = fusion_pkg::sample_t'(CLIP_MAX);
            end else begin
                conditioned[i] = word;
            end
        end
    end

    // Window must lie inside the signed word range
    initial begin
        assert (CLIP_MIN <= CLIP_MAX && CLIP_MIN >= fusion_pkg::WORD_MIN &&
                CLIP_MAX <= fusion_pkg::WORD_MAX)
        else $error("sensor_conditioner: clip window outside the word range");
    end

endmodule

/* rtl/fault_monitor.sv */
// Checksum check plus range and signal-loss histories for all sensors, advanced per accepted request
`timescale 1ns/1ps

module fault_monitor #(
    parameter int RANGE_LIMIT = 10000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fusion_pkg::frame_set_t  frames,
    input  logic                    update,     // Acceptance strobe
    output fusion_pkg::fault_code_t fault
);

    localparam int NS = fusion_pkg::N_SENSORS;
    localparam int HW = fusion_pkg::HIST_LEN - 1;  // Earlier requests remembered

    logic [NS-1:0] sum_bad;
    logic [NS-1:0] range_now;
    logic [NS-1:0] loss_now;
    logic [NS-1:0] range_persist;
    logic [NS-1:0] loss_persist;

    logic [NS-1:0][HW-1:0] range_hist;  // Bit 0 is the most recent accepted request
    logic [NS-1:0][HW-1:0] loss_hist;

    always_comb begin : frame_checks
        logic [fusion_pkg::WORD_W-1:0] sum;
        fusion_pkg::sample_t           word;
        for (int s = 0; s < NS; s++) begin
            sum          = '0;
            range_now[s] = 1'b0;
            for (int i = 0; i < fusion_pkg::N_WORDS; i++) begin
                word = $signed(frames[s].data[i]);
                sum  = sum + word;  // Wrapping 16-bit sum
                if (word > RANGE_LIMIT || word < -RANGE_LIMIT) begin
                    range_now[s] = 1'b1;
                end
            end
            sum_bad[s]       = (sum != frames[s].checksum);
            loss_now[s]      = (frames[s] == '0);  // Checksum counts in the zero test
            range_persist[s] = range_now[s] && (&range_hist[s]);
            loss_persist[s]  = loss_now[s] && (&loss_hist[s]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            range_hist <= '0;
            loss_hist  <= '0;
        end else if (update) begin
            for (int s = 0; s < NS; s++) begin
                range_hist[s] <= HW'({range_hist[s], range_now[s]});
                loss_hist[s]  <= HW'({loss_hist[s], loss_now[s]});
            end
        end
    end

    always_comb begin
        fault.reserved     = 1'b0;
        fault.loss_err     = |loss_persist;
        fault.range_err    = |range_persist;
        fault.checksum_err = |sum_bad;
    end

    // An all-zero frame always lies inside the range window
    a_loss_not_range: assert property (@(posedge clk) disable iff (!rst_n)
        (loss_now & range_now) == '0);

endmodule

/* rtl/qkv_projector.sv */
// Projects one conditioned vector through the Q, K and V weight tables with 16-bit saturation
`timescale 1ns/1ps

module qkv_projector (
    input  fusion_pkg::vec_t x,
    output fusion_pkg::qkv_t qkv
);

    // Four 16x16 products need two guard bits
    localparam int ACC_W = 2 * fusion_pkg::WORD_W + 2;

    logic signed [ACC_W-1:0] acc_q [fusion_pkg::N_WORDS];
    logic signed [ACC_W-1:0] acc_k [fusion_pkg::N_WORDS];
    logic signed [ACC_W-1:0] acc_v [fusion_pkg::N_WORDS];

    always_comb begin
        for (int j = 0; j < fusion_pkg::N_WORDS; j++) begin
            acc_q[j] = '0;
            acc_k[j] = '0;
            acc_v[j] = '0;
            // Row j of each table against the input vector
            for (int k = 0; k < fusion_pkg::N_WORDS; k++) begin
                acc_q[j] = acc_q[j] + fusion_pkg::W_Q[j][k] * $signed(x[k]);
                acc_k[j] = acc_k[j] + fusion_pkg::W_K[j][k] * $signed(x[k]);
                acc_v[j] = acc_v[j] + fusion_pkg::W_V[j][k] * $signed(x[k]);
            end
            qkv.q[j] = fusion_pkg::sat_word(acc_q[j]);
            qkv.k[j] = fusion_pkg::sat_word(acc_k[j]);
            qkv.v[j] = fusion_pkg::sat_word(acc_v[j]);
        end
    end

endmodule

/* rtl/attention_fuser.sv */
// Computes one sensor's attention score from Q and K and scales its V vector into a fused vector
`timescale 1ns/1ps

module attention_fuser #(
    parameter int ATTN_SHIFT = 2,
    parameter int ATTN_BIAS  = 0
) (
    input  fusion_pkg::qkv_t qkv,
    output fusion_pkg::vec_t fused
);

    localparam int DOT_W  = 2 * fusion_pkg::WORD_W + 2;              // Sum of four products
    localparam int PROD_W = fusion_pkg::SCORE_W + fusion_pkg::WORD_W;

    logic signed [DOT_W-1:0]  dot;
    logic signed [DOT_W:0]    biased;   // One more bit for the bias
    fusion_pkg::score_t       score;
    logic signed [PROD_W-1:0] scaled [fusion_pkg::N_WORDS];

    // Score: (Q . K) >>> shift + bias, clamped to 32 bits
    always_comb begin
        dot = '0;
        for (int i = 0; i < fusion_pkg::N_WORDS; i++) begin
            dot = dot + $signed(qkv.q[i]) * $signed(qkv.k[i]);
        end
        biased = (dot >>> ATTN_SHIFT) + ATTN_BIAS;
        score  = fusion_pkg::sat_score(biased);
    end

    // Score taken as Q8.8, so each product drops FRAC_BITS
    always_comb begin
        for (int i = 0; i < fusion_pkg::N_WORDS; i++) begin
            scaled[i] = (score * $signed(qkv.v[i])) >>> fusion_pkg::FRAC_BITS;
            fused[i]  = fusion_pkg::sat_word(scaled[i]);
        end
    end

endmodule

/* rtl/fusion_core.sv */
// Top of the three-sensor fusion pipeline with four-phase req/ack on input and output
`timescale 1ns/1ps

module fusion_core #(
    parameter int CLIP_MIN    = -16384,
    parameter int CLIP_MAX    = 16383,
    parameter int RANGE_LIMIT = 10000,
    parameter int ATTN_SHIFT  = 2,
    parameter int ATTN_BIAS   = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_req,
    output logic                    in_ack,
    input  fusion_pkg::frame_set_t  in_frames,
    output logic                    out_req,
    input  logic                    out_ack,
    output fusion_pkg::fused_set_t  out_fused,
    output fusion_pkg::fault_code_t out_fault
);

    localparam int NS = fusion_pkg::N_SENSORS;

    fusion_pkg::vec_t [NS-1:0] cond_vec;     // Conditioner outputs
    fusion_pkg::qkv_t [NS-1:0] proj_qkv;     // Projector outputs
    fusion_pkg::fused_set_t    fuse_vec;
    fusion_pkg::fault_code_t   mon_fault;

    logic s1_valid;
    logic s2_valid;
    logic s3_valid;                          // Output slot
    fusion_pkg::vec_t [NS-1:0] s1_vec;
    fusion_pkg::qkv_t [NS-1:0] s2_qkv;
    fusion_pkg::fused_set_t    s3_fused;
    fusion_pkg::fault_code_t   s1_fault;
    fusion_pkg::fault_code_t   s2_fault;
    fusion_pkg::fault_code_t   s3_fault;

    logic out_done;
    logic s3_free;
    logic s2_adv;
    logic s2_free;
    logic s1_adv;
    logic s1_free;
    logic accept;

    // A stage may load when the next one is empty or emptying on this edge
    assign out_done = out_req && out_ack;
    assign s3_free  = !s3_valid || out_done;
    assign s2_adv   = s2_valid && s3_free;
    assign s2_free  = !s2_valid || s2_adv;
    assign s1_adv   = s1_valid && s2_free;
    assign s1_free  = !s1_valid || s1_adv;
    assign accept   = in_req && !in_ack && s1_free;

    for (genvar s = 0; s < NS; s++) begin : g_sensor
        sensor_conditioner #(
            .CLIP_MIN(CLIP_MIN),
            .CLIP_MAX(CLIP_MAX)
        ) u_cond (
            .frame      (in_frames[s]),
            .conditioned(cond_vec[s])
        );

        qkv_projector u_proj (
            .x  (s1_vec[s]),
            .qkv(proj_qkv[s])
        );

        attention_fuser #(
            .ATTN_SHIFT(ATTN_SHIFT),
            .ATTN_BIAS (ATTN_BIAS)
        ) u_fuse (
            .qkv  (s2_qkv[s]),
            .fused(fuse_vec[s])
        );
    end

    fault_monitor #(
        .RANGE_LIMIT(RANGE_LIMIT)
    ) u_monitor (
        .clk   (clk),
        .rst_n (rst_n),
        .frames(in_frames),
        .update(accept),
        .fault (mon_fault)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack   <= 1'b0;
            out_req  <= 1'b0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            if (accept) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;       // Return to zero after req drops
            end
            if (accept) begin
                s1_valid <= 1'b1;
            end else if (s1_adv) begin
                s1_valid <= 1'b0;
            end
            if (s1_adv) begin
                s2_valid <= 1'b1;
            end else if (s2_adv) begin
                s2_valid <= 1'b0;
            end
            if (s2_adv) begin
                s3_valid <= 1'b1;
            end else if (out_done) begin
                s3_valid <= 1'b0;
            end
            // New result only once the previous ack has gone low
            if (out_done) begin
                out_req <= 1'b0;
            end else if (s3_valid && !out_ack) begin
                out_req <= 1'b1;
            end
        end
    end

    // Payload registers follow their stage's load strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_vec   <= cond_vec;
            s1_fault <= mon_fault;
        end
        if (s1_adv) begin
            s2_qkv   <= proj_qkv;
            s2_fault <= s1_fault;
        end
        if (s2_adv) begin
            s3_fused <= fuse_vec;
            s3_fault <= s2_fault;
        end
    end

    assign out_fused = s3_fused;
    assign out_fault = s3_fault;

    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req));

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req && $stable(out_fused) && $stable(out_fault));

endmodule

/* dv/fusion_core_tests.svh */
// Directed test tasks and frame builders, included inside the fusion pipeline testbench module

// Frame with a matching 16-bit wrapping checksum
function automatic fusion_pkg::sensor_frame_t make_frame(input int w0, input int w1,
                                                         input int w2, input int w3);
    fusion_pkg::sensor_frame_t f;
    f.data[0]  = fusion_pkg::sample_t'(w0);
    f.data[1]  = fusion_pkg::sample_t'(w1);
    f.data[2]  = fusion_pkg::sample_t'(w2);
    f.data[3]  = fusion_pkg::sample_t'(w3);
    f.checksum = f.data[0] + f.data[1] + f.data[2] + f.data[3];
    return f;
endfunction

function automatic fusion_pkg::sensor_frame_t random_frame(input int limit);
    int w [fusion_pkg::N_WORDS];
    for (int i = 0; i < fusion_pkg::N_WORDS; i++) begin
        w[i] = int'($urandom % (2 * limit + 1)) - limit;   // Uniform in +-limit
    end
    return make_frame(w[0], w[1], w[2], w[3]);
endfunction

function automatic fusion_pkg::frame_set_t frame_set(input fusion_pkg::sensor_frame_t f0,
                                                     input fusion_pkg::sensor_frame_t f1,
                                                     input fusion_pkg::sensor_frame_t f2);
    fusion_pkg::frame_set_t set;
    set[0] = f0;
    set[1] = f1;
    set[2] = f2;
    return set;
endfunction

task automatic test_nominal();
    test_name = "nominal";
    for (int r = 0; r < 6; r++) begin
        send_request(frame_set(random_frame(3000), random_frame(3000), random_frame(3000)));
    end
    wait_drain();
endtask

// Words beyond the window get clipped, large vectors saturate projection and fusion
task automatic test_clip_saturation();
    test_name = "clip_saturation";
    send_request(frame_set(make_frame(32767, -32768, 30000, -30000),
                           make_frame(16383, 16383, 16383, 16383),
                           make_frame(-16384, 16383, -16384, 16383)));
    send_request(frame_set(make_frame(-32768, -32768, -32768, -32768),
                           make_frame(20000, 100, -100, 12000),
                           make_frame(16383, -16384, 16383, -16384)));
    send_request(frame_set(make_frame(16383, 16383, -16384, 16383),
                           make_frame(-20000, 25000, 16000, -9000),
                           make_frame(12000, 12000, 12000, 12000)));
    wait_drain();
endtask

task automatic test_checksum();
    fusion_pkg::sensor_frame_t bad;
    test_name = "checksum";
    bad          = make_frame(100, 200, 300, 400);
    bad.checksum = bad.checksum + 16'd1;
    send_request(frame_set(random_frame(2000), random_frame(2000), random_frame(2000)));
    send_request(frame_set(random_frame(2000), bad, random_frame(2000)));
    send_request(frame_set(random_frame(2000), random_frame(2000), random_frame(2000)));
    wait_drain();
endtask

// Range fault on sensor 2, then signal loss on sensor 0, each ended by a good request
task automatic test_persistent_faults();
    fusion_pkg::sensor_frame_t far;
    test_name = "range_history";
    far = make_frame(12000, 50, -50, 0);
    send_request(frame_set(random_frame(2000), random_frame(2000), random_frame(2000)));
    repeat (3) send_request(frame_set(random_frame(2000), random_frame(2000), far));
    send_request(frame_set(random_frame(2000), random_frame(2000), random_frame(2000)));
    test_name = "loss_history";
    repeat (3) send_request(frame_set('0, random_frame(2000), random_frame(2000)));
    send_request(frame_set(random_frame(2000), random_frame(2000), random_frame(2000)));
    wait_drain();
endtask

task automatic test_backpressure();
    test_name     = "backpressure";
    ack_hold_min  = 5;
    ack_hold_max  = 20;
    max_in_flight = 0;
    for (int r = 0; r < 8; r++) begin
        send_request(frame_set(random_frame(8000), random_frame(8000), random_frame(8000)));
    end
    wait_drain();
    ack_hold_max = 0;
    if (max_in_flight != PIPE_DEPTH) begin
        protocol_errors++;
        $display("Back-pressure never filled all %0d pipeline stages", PIPE_DEPTH);
    end
endtask

task automatic test_latency();
    test_name     = "latency";
    check_latency = 1'b1;
    repeat (2) begin
        send_request(frame_set(random_frame(3000), random_frame(3000), random_frame(3000)));
        wait_drain();
    end
    check_latency = 1'b0;
endtask

/* dv/fusion_core_tb.sv */
// Runs the directed tests against fusion_core and checks its results with a reference model
`timescale 1ns/1ps

module fusion_core_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int CLIP_MIN     = -16384;
    localparam int CLIP_MAX     = 16383;
    localparam int RANGE_LIMIT  = 10000;
    localparam int ATTN_SHIFT   = 2;
    localparam int ATTN_BIAS    = 0;
    localparam int PIPE_DEPTH   = 3;     // Stages that can hold a request
    localparam int N_REQUESTS   = 31;    // Requests issued over all tests
    localparam int WATCHDOG_NS  = N_REQUESTS * 40 * CLK_PERIOD + 2000;
    localparam int WAIT_CYCLES  = 200;
    localparam int DRAIN_CYCLES = 1000;
    localparam longint WORD_HI  = 64'sd32767;
    localparam longint WORD_LO  = -64'sd32768;
    localparam longint SCORE_HI = 64'sd2147483647;
    localparam longint SCORE_LO = -64'sd2147483648;

    logic                    clk;
    logic                    rst_n;
    logic                    in_req;
    logic                    in_ack;
    fusion_pkg::frame_set_t  in_frames;
    logic                    out_req;
    logic                    out_ack;
    fusion_pkg::fused_set_t  out_fused;
    fusion_pkg::fault_code_t out_fault;

    int    fused_errors = 0;
    int    fault_errors = 0;
    int    protocol_errors = 0;   // Handshake, latency and ordering problems
    int    cycle_count = 0;
    int    in_flight = 0;
    int    max_in_flight = 0;
    logic  in_ack_d = 1'b0;
    string test_name = "reset";
    int    ack_hold_min = 0;
    int    ack_hold_max = 0;      // Zero means out_ack answers at once
    bit    check_latency = 1'b0;

    fusion_pkg::fused_set_t  exp_fused_q[$];
    fusion_pkg::fault_code_t exp_fault_q[$];
    string                   exp_name_q[$];
    int                      exp_accept_q[$];   // Cycle at which in_ack was first seen

    int range_run [fusion_pkg::N_SENSORS];      // Model history as bad requests in a row
    int loss_run  [fusion_pkg::N_SENSORS];

    fusion_core #(
        .CLIP_MIN   (CLIP_MIN),
        .CLIP_MAX   (CLIP_MAX),
        .RANGE_LIMIT(RANGE_LIMIT),
        .ATTN_SHIFT (ATTN_SHIFT),
        .ATTN_BIAS  (ATTN_BIAS)
    ) fusion_core_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_frames(in_frames),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_fused(out_fused),
        .out_fault(out_fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic longint clamp(input longint value, input longint lo, input longint hi);
        if (value < lo)
            return lo;
        if (value > hi)
            return hi;
        return value;
    endfunction

    // Expected result of one accepted request with its own fault history
    function automatic void model_request(input fusion_pkg::frame_set_t frames,
                                          output fusion_pkg::fused_set_t fused,
                                          output fusion_pkg::fault_code_t fault);
        longint      x [fusion_pkg::N_WORDS];
        longint      q [fusion_pkg::N_WORDS];
        longint      k [fusion_pkg::N_WORDS];
        longint      v [fusion_pkg::N_WORDS];
        longint      dot;
        longint      score;
        logic [15:0] sum;
        bit          beyond;
        bit          silent;
        fused = '0;
        fault = '0;
        for (int s = 0; s < fusion_pkg::N_SENSORS; s++) begin
            sum    = '0;
            beyond = 1'b0;
            silent = (frames[s] == '0);   // Checksum included
            for (int i = 0; i < fusion_pkg::N_WORDS; i++) begin
                x[i]   = longint'(frames[s].data[i]);
                sum    = sum + frames[s].data[i];
                beyond = beyond || x[i] > RANGE_LIMIT || x[i] < -RANGE_LIMIT;
                x[i]   = clamp(x[i], CLIP_MIN, CLIP_MAX);
            end
            if (sum != frames[s].checksum)
                fault.checksum_err = 1'b1;
            if (beyond && range_run[s] >= fusion_pkg::HIST_LEN - 1)
                fault.range_err = 1'b1;
            if (silent && loss_run[s] >= fusion_pkg::HIST_LEN - 1)
                fault.loss_err = 1'b1;
            range_run[s] = beyond ? range_run[s] + 1 : 0;
            loss_run[s]  = silent ? loss_run[s] + 1 : 0;
            dot = 0;
            for (int j = 0; j < fusion_pkg::N_WORDS; j++) begin
                q[j] = 0;
                k[j] = 0;
                v[j] = 0;
                for (int c = 0; c < fusion_pkg::N_WORDS; c++) begin
                    q[j] += longint'(fusion_pkg::W_Q[j][c]) * x[c];
                    k[j] += longint'(fusion_pkg::W_K[j][c]) * x[c];
                    v[j] += longint'(fusion_pkg::W_V[j][c]) * x[c];
                end
                q[j] = clamp(q[j], WORD_LO, WORD_HI);
                k[j] = clamp(k[j], WORD_LO, WORD_HI);
                v[j] = clamp(v[j], WORD_LO, WORD_HI);
                dot += q[j] * k[j];
            end
            score = clamp((dot >>> ATTN_SHIFT) + ATTN_BIAS, SCORE_LO, SCORE_HI);
            for (int i = 0; i < fusion_pkg::N_WORDS; i++) begin
                fused[s][i] = fusion_pkg::sample_t'(clamp((score * v[i]) >>> fusion_pkg::FRAC_BITS,
                                                          WORD_LO, WORD_HI));
            end
        end
    endfunction

    task automatic compare_fused(input string name, input fusion_pkg::fused_set_t exp,
                                 input fusion_pkg::fused_set_t act);
        if (act !== exp) begin
            fused_errors++;
            $display("** Error %s: fused set expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_fault(input string name, input fusion_pkg::fault_code_t exp,
                                 input fusion_pkg::fault_code_t act);
        if (act !== exp) begin
            fault_errors++;
            $display("** Error %s: fault code expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic compare_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            protocol_errors++;
            $display("** Error %s: latency expected %0d cycles, actual %0d cycles", name, exp, act);
        end
    endtask

    // Counts requests held by the DUT so that in_ack rising into a full pipeline is caught
    always @(posedge clk) begin
        if (rst_n) begin
            if (out_req && out_ack)
                in_flight = in_flight - 1;
            if (in_ack && !in_ack_d) begin
                in_flight = in_flight + 1;
                if (in_flight > PIPE_DEPTH) begin
                    protocol_errors++;
                    $display("in_ack rose at %0t while the pipeline was already full", $time);
                end
                if (in_flight > max_in_flight)
                    max_in_flight = in_flight;
            end
        end
        in_ack_d = in_ack;
    end

    // Output side of the handshake with each result checked in arrival order
    initial begin : collect_results
        fusion_pkg::fused_set_t  exp_fused;
        fusion_pkg::fault_code_t exp_fault;
        string                   name;
        int                      accepted_at;
        int                      hold;
        int                      waited;
        forever begin
            @(posedge clk);
            if (out_req && !out_ack) begin
                if (exp_fused_q.size() == 0) begin
                    protocol_errors++;
                    $display("A result was presented at %0t with no request outstanding", $time);
                end else begin
                    exp_fused   = exp_fused_q.pop_front();
                    exp_fault   = exp_fault_q.pop_front();
                    name        = exp_name_q.pop_front();
                    accepted_at = exp_accept_q.pop_front();
                    compare_fused(name, exp_fused, out_fused);
                    compare_fault(name, exp_fault, out_fault);
                    if (check_latency)
                        compare_latency(name, PIPE_DEPTH, cycle_count - accepted_at);
                end
                hold = 0;
                if (ack_hold_max > 0)
                    hold = ack_hold_min + int'($urandom % (ack_hold_max - ack_hold_min + 1));
                repeat (hold) @(posedge clk);
                out_ack <= 1'b1;
                waited = 0;
                do begin
                    @(posedge clk);
                    waited++;
                end while (out_req && waited < WAIT_CYCLES);
                if (out_req) begin
                    protocol_errors++;
                    $display("out_req did not fall after out_ack was raised");
                end
                out_ack <= 1'b0;
            end
        end
    end

    // Drives one request through the input handshake just after a rising edge
    task automatic send_request(input fusion_pkg::frame_set_t frames);
        fusion_pkg::fused_set_t  exp_fused;
        fusion_pkg::fault_code_t exp_fault;
        int                      waited;
        in_frames <= frames;
        in_req    <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!in_ack && waited < WAIT_CYCLES);
        if (!in_ack) begin
            protocol_errors++;
            $display("in_ack never answered a request in test %s", test_name);
            in_req <= 1'b0;
            return;
        end
        model_request(frames, exp_fused, exp_fault);
        exp_fused_q.push_back(exp_fused);
        exp_fault_q.push_back(exp_fault);
        exp_name_q.push_back(test_name);
        exp_accept_q.push_back(cycle_count);
        in_req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (in_ack && waited < WAIT_CYCLES);
        if (in_ack) begin
            protocol_errors++;
            $display("in_ack stayed high after in_req fell in test %s", test_name);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_fused_q.size() != 0 || out_req || out_ack) && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (exp_fused_q.size() != 0) begin
            protocol_errors++;
            $display("%0d results of test %s never arrived", exp_fused_q.size(), test_name);
        end
    endtask

    `include "fusion_core_tests.svh"

    initial begin : run_tests
        int total;
        void'($urandom(41));
        rst_n     = 1'b0;
        in_req    = 1'b0;
        in_frames = '0;
        out_ack   = 1'b0;
        for (int s = 0; s < fusion_pkg::N_SENSORS; s++) begin
            range_run[s] = 0;
            loss_run[s]  = 0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_nominal();
        test_clip_saturation();
        test_checksum();
        test_persistent_faults();
        test_backpressure();
        test_latency();
        total = fused_errors + fault_errors + protocol_errors;
        $display("Error counts: fused %0d, fault %0d, protocol %0d", fused_errors, fault_errors,
                 protocol_errors);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* fusion_core.f */
+incdir+dv
rtl/fusion_pkg.sv
rtl/sensor_conditioner.sv
rtl/fault_monitor.sv
rtl/qkv_projector.sv
rtl/attention_fuser.sv
rtl/fusion_core.sv
dv/fusion_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fusion pipeline testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"
verilator --binary --timing --assert -Wno-fatal \
    --top-module fusion_core_tb -f fusion_core.f \
    -Mdir "$BUILD_DIR/obj_dir" -o fusion_core_sim

"$BUILD_DIR/obj_dir/fusion_core_sim" | tee "$LOG_FILE"

if grep -qx "TB PASSED" "$LOG_FILE"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
